/* design/ntm_scalar_params.svh */
// Width macros shared by every RTL file; operands must stay below a nonzero modulus
`ifndef NTM_SCALAR_PARAMS_SVH
`define NTM_SCALAR_PARAMS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Operand, modulus and result width
`define NTM_DATA_SIZE 16

// Summation length and loop index width
`define NTM_LENGTH_SIZE 8

//////////////////////////////
// Notes
//////////////////////////////

// Data width sets the multiplier bit count,
// so latency of one product grows linearly with it

// A length of zero is taken as one by the
// summation unit

`endif

/* design/ntm_arith_pkg.sv */
// Adder request and result words; all operands assumed already reduced below the modulus
`default_nettype none

`include "ntm_scalar_params.svh"

package ntm_arith_pkg;

  //////////////////////////////
  // Adder request
  //////////////////////////////

  // Three words into the shared modular adder
  // Modulus must be nonzero
  typedef struct packed {
    logic [`NTM_DATA_SIZE-1:0] a;
    logic [`NTM_DATA_SIZE-1:0] b;
    logic [`NTM_DATA_SIZE-1:0] modulus;
  } adder_req_t;

  //////////////////////////////
  // Adder result
  //////////////////////////////

  // Reduced sum, always below the modulus
  typedef struct packed {
    logic [`NTM_DATA_SIZE-1:0] sum;
  } adder_rsp_t;

endpackage

`default_nettype wire

/* design/ntm_ctrl_pkg.sv */
// FSM state encodings and arbiter client index; one client per function unit
`default_nettype none

`include "ntm_scalar_params.svh"

package ntm_ctrl_pkg;

  // Summation loop, same three steps as the original FSM
  typedef enum logic [1:0] {
    SUM_STARTER = 2'd0,
    SUM_INPUT   = 2'd1,
    SUM_ENDER   = 2'd2
  } summation_state_t;

  // Double-and-add sequencing
  typedef enum logic [2:0] {
    MUL_IDLE     = 3'd0,
    MUL_DBL_REQ  = 3'd1,
    MUL_DBL_WAIT = 3'd2,
    MUL_ADD_REQ  = 3'd3,
    MUL_ADD_WAIT = 3'd4
  } multiplier_state_t;

  // Zero is summation, one is multiplier
  typedef enum logic {
    CLIENT_SUM = 1'b0,
    CLIENT_MUL = 1'b1
  } client_id_t;

endpackage

`default_nettype wire

/* design/ntm_scalar_adder.sv */
// Single-cycle modular adder; operands must be below a nonzero modulus, result valid with ready
`timescale 1ns/1ps
`default_nettype none

`include "ntm_scalar_params.svh"

module ntm_scalar_adder
  import ntm_arith_pkg::*;
(
  input  wire logic       CLK,
  input  wire logic       RST,
  input  wire logic       start,
  input  wire adder_req_t req,
  output logic            ready,
  output adder_rsp_t      rsp
);

  //////////////////////////////
  // Sum and reduction
  //////////////////////////////

  // One extra bit keeps the carry
  logic [`NTM_DATA_SIZE:0]   sum_ext;
  logic [`NTM_DATA_SIZE-1:0] sum_red;

  assign sum_ext = {1'b0, req.a} + {1'b0, req.b};

  // Both inputs below m, so one subtraction is enough
  always_comb begin
    if (sum_ext >= {1'b0, req.modulus}) begin
      sum_red = sum_ext[`NTM_DATA_SIZE-1:0] - req.modulus;
    end else begin
      sum_red = sum_ext[`NTM_DATA_SIZE-1:0];
    end
  end

  // Ready follows start by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready <= 1'b0;
    end else begin
      ready <= start;
    end
  end

  // Result register
  always_ff @(posedge CLK) begin
    if (start) begin
      rsp.sum <= sum_red;
    end
  end

  // Arbiter must wait for ready before the next start
  a_no_start_on_ready : assert property (@(posedge CLK) disable iff (RST)
    !(start && ready));

endmodule

`default_nettype wire

/* design/ntm_adder_arbiter.sv */
// Round-robin share of one adder; each client must hold its request until its ready pulse
`timescale 1ns/1ps
`default_nettype none

`include "ntm_scalar_params.svh"

module ntm_adder_arbiter
  import ntm_arith_pkg::*, ntm_ctrl_pkg::*;
(
  input  wire logic       CLK,
  input  wire logic       RST,
  input  wire logic       sum_start,
  input  wire adder_req_t sum_req,
  input  wire logic       mul_start,
  input  wire adder_req_t mul_req,
  input  wire logic       adder_ready,
  input  wire adder_rsp_t adder_rsp,
  output logic            sum_ready,
  output logic            mul_ready,
  output adder_rsp_t      rsp,
  output logic            adder_start,
  output adder_req_t      adder_req
);

  logic       sum_pend, mul_pend, busy;
  logic       sum_want, mul_want, grant;
  // Owner of the request in flight, also the round-robin pointer
  client_id_t owner;
  client_id_t pick;

  // Fresh start counts as a request in the same cycle
  assign sum_want = sum_pend | sum_start;
  assign mul_want = mul_pend | mul_start;
  // Adder free, or freeing up this cycle
  assign grant    = (sum_want | mul_want) & (~busy | adder_ready);

  // Both waiting, so serve the one not served last
  always_comb begin
    if (sum_want && mul_want) begin
      pick = (owner == CLIENT_SUM) ? CLIENT_MUL : CLIENT_SUM;
    end else if (mul_want) begin
      pick = CLIENT_MUL;
    end else begin
      pick = CLIENT_SUM;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum_pend <= 1'b0;
      mul_pend <= 1'b0;
      busy <= 1'b0;
      owner <= CLIENT_SUM;
      adder_start <= 1'b0;
      sum_ready <= 1'b0;
      mul_ready <= 1'b0;
    end else begin
      adder_start <= grant;
      sum_pend <= sum_want & ~(grant && (pick == CLIENT_SUM));
      mul_pend <= mul_want & ~(grant && (pick == CLIENT_MUL));
      if (grant) begin
        owner <= pick;
        busy <= 1'b1;
      end else if (adder_ready) begin
        busy <= 1'b0;
      end
      // Route back to whoever owned the finished request
      sum_ready <= adder_ready && (owner == CLIENT_SUM);
      mul_ready <= adder_ready && (owner == CLIENT_MUL);
    end
  end

  // Request and result words
  always_ff @(posedge CLK) begin
    if (grant) begin
      adder_req <= (pick == CLIENT_SUM) ? sum_req : mul_req;
    end
    if (adder_ready) begin
      rsp <= adder_rsp;
    end
  end

  // One outstanding request per client
  a_sum_one_pending : assert property (@(posedge CLK) disable iff (RST)
    sum_start |-> !sum_pend);
  a_mul_one_pending : assert property (@(posedge CLK) disable iff (RST)
    mul_start |-> !mul_pend);
  a_ready_onehot : assert property (@(posedge CLK) disable iff (RST)
    !(sum_ready && mul_ready));

endmodule

`default_nettype wire

/* design/ntm_scalar_summation_function.sv */
// Modular accumulator; inputs outside the input state are dropped, so wait for each DATA_OUT_ENABLE
`timescale 1ns/1ps
`default_nettype none

`include "ntm_scalar_params.svh"

module ntm_scalar_summation_function
  import ntm_arith_pkg::*, ntm_ctrl_pkg::*;
(
  input  wire logic                        CLK,
  input  wire logic                        RST,
  input  wire logic                        START,
  input  wire logic [`NTM_LENGTH_SIZE-1:0] LENGTH_IN,
  input  wire logic [`NTM_DATA_SIZE-1:0]   MODULO_IN,
  input  wire logic [`NTM_DATA_SIZE-1:0]   DATA_IN,
  input  wire logic                        DATA_IN_ENABLE,
  input  wire logic                        adder_ready,
  input  wire adder_rsp_t                  adder_rsp,
  output logic                             READY,
  output logic                             DATA_OUT_ENABLE,
  output logic [`NTM_DATA_SIZE-1:0]        DATA_OUT,
  output logic                             adder_start,
  output adder_req_t                       adder_req
);

  //////////////////////////////
  // State
  //////////////////////////////

  summation_state_t              state;
  logic [`NTM_LENGTH_SIZE-1:0]   index_loop;
  logic [`NTM_LENGTH_SIZE-1:0]   last_index;
  logic [`NTM_DATA_SIZE-1:0]     modulo;
  logic [`NTM_DATA_SIZE-1:0]     acc;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= SUM_STARTER;
      READY <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      adder_start <= 1'b0;
      index_loop <= '0;
    end else begin
      // Pulses last one cycle
      READY <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      adder_start <= 1'b0;
      case (state)
        SUM_STARTER: begin
          if (START) begin
            index_loop <= '0;
            state <= SUM_INPUT;
          end
        end
        SUM_INPUT: begin
          // One adder request per accepted input
          if (DATA_IN_ENABLE) begin
            adder_start <= 1'b1;
            state <= SUM_ENDER;
          end
        end
        SUM_ENDER: begin
          if (adder_ready) begin
            DATA_OUT_ENABLE <= 1'b1;
            if (index_loop == last_index) begin
              READY <= 1'b1;
              state <= SUM_STARTER;
            end else begin
              index_loop <= index_loop + 1'b1;
              state <= SUM_INPUT;
            end
          end
        end
        default: begin
          state <= SUM_STARTER;
        end
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Latched length and modulus, accumulator, request word
  always_ff @(posedge CLK) begin
    if (state == SUM_STARTER && START) begin
      // Zero length runs as one input
      last_index <= (LENGTH_IN == '0) ? '0 : LENGTH_IN - 1'b1;
      modulo <= MODULO_IN;
      acc <= '0;
    end
    // Held until the arbiter sends ready
    if (state == SUM_INPUT && DATA_IN_ENABLE) begin
      adder_req.a <= acc;
      adder_req.b <= DATA_IN;
      adder_req.modulus <= modulo;
    end
    // Partial sum goes out with the enable
    if (state == SUM_ENDER && adder_ready) begin
      acc <= adder_rsp.sum;
      DATA_OUT <= adder_rsp.sum;
    end
  end

endmodule

`default_nettype wire

/* design/ntm_scalar_multiplier.sv */
// Double-and-add modular product; A and B must be below a nonzero modulus, latency varies with B
`timescale 1ns/1ps
`default_nettype none

`include "ntm_scalar_params.svh"

module ntm_scalar_multiplier
  import ntm_arith_pkg::*, ntm_ctrl_pkg::*;
(
  input  wire logic                      CLK,
  input  wire logic                      RST,
  input  wire logic                      START,
  input  wire logic [`NTM_DATA_SIZE-1:0] MODULO_IN,
  input  wire logic [`NTM_DATA_SIZE-1:0] DATA_A_IN,
  input  wire logic [`NTM_DATA_SIZE-1:0] DATA_B_IN,
  input  wire logic                      adder_ready,
  input  wire adder_rsp_t                adder_rsp,
  output logic                           READY,
  output logic [`NTM_DATA_SIZE-1:0]      DATA_OUT,
  output logic                           adder_start,
  output adder_req_t                     adder_req
);

  localparam int BIT_W = $clog2(`NTM_DATA_SIZE);

  multiplier_state_t         state;
  logic [BIT_W-1:0]          bit_idx;
  logic [`NTM_DATA_SIZE-1:0] op_a;
  logic [`NTM_DATA_SIZE-1:0] op_b;
  logic [`NTM_DATA_SIZE-1:0] modulo;
  logic [`NTM_DATA_SIZE-1:0] acc;
  logic                      last_bit;

  assign last_bit = (bit_idx == '0);

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= MUL_IDLE;
      READY <= 1'b0;
      adder_start <= 1'b0;
      bit_idx <= '0;
    end else begin
      READY <= 1'b0;
      adder_start <= 1'b0;
      case (state)
        MUL_IDLE: begin
          if (START) begin
            // Scan from the MSB of B
            bit_idx <= BIT_W'(`NTM_DATA_SIZE - 1);
            state <= MUL_DBL_REQ;
          end
        end
        MUL_DBL_REQ: begin
          adder_start <= 1'b1;
          state <= MUL_DBL_WAIT;
        end
        MUL_DBL_WAIT: begin
          if (adder_ready) begin
            if (op_b[bit_idx]) begin
              state <= MUL_ADD_REQ;
            end else if (last_bit) begin
              READY <= 1'b1;
              state <= MUL_IDLE;
            end else begin
              bit_idx <= bit_idx - 1'b1;
              state <= MUL_DBL_REQ;
            end
          end
        end
        MUL_ADD_REQ: begin
          adder_start <= 1'b1;
          state <= MUL_ADD_WAIT;
        end
        MUL_ADD_WAIT: begin
          if (adder_ready) begin
            if (last_bit) begin
              READY <= 1'b1;
              state <= MUL_IDLE;
            end else begin
              bit_idx <= bit_idx - 1'b1;
              state <= MUL_DBL_REQ;
            end
          end
        end
        default: begin
          state <= MUL_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == MUL_IDLE && START) begin
      op_a <= DATA_A_IN;
      op_b <= DATA_B_IN;
      modulo <= MODULO_IN;
      acc <= '0;
    end
    // Doubling is acc plus acc
    if (state == MUL_DBL_REQ) begin
      adder_req <= '{a: acc, b: acc, modulus: modulo};
    end
    if (state == MUL_ADD_REQ) begin
      adder_req <= '{a: acc, b: op_a, modulus: modulo};
    end
    if ((state == MUL_DBL_WAIT || state == MUL_ADD_WAIT) && adder_ready) begin
      acc <= adder_rsp.sum;
    end
    // Product held until the next run ends
    if (state == MUL_DBL_WAIT && adder_ready && !op_b[bit_idx] && last_bit) begin
      DATA_OUT <= adder_rsp.sum;
    end
    if (state == MUL_ADD_WAIT && adder_ready && last_bit) begin
      DATA_OUT <= adder_rsp.sum;
    end
  end

endmodule

`default_nettype wire

/* design/ntm_scalar_unit.sv */
// Top of the scalar engine; both units share one adder, so latency grows under contention
`timescale 1ns/1ps
`default_nettype none

`include "ntm_scalar_params.svh"

module ntm_scalar_unit
  import ntm_arith_pkg::*;
(
  input  wire logic                        CLK,
  input  wire logic                        RST,
  // Summation side
  input  wire logic                        sum_start,
  input  wire logic [`NTM_LENGTH_SIZE-1:0] sum_length,
  input  wire logic [`NTM_DATA_SIZE-1:0]   sum_modulo,
  input  wire logic [`NTM_DATA_SIZE-1:0]   sum_data_in,
  input  wire logic                        sum_data_in_enable,
  output logic [`NTM_DATA_SIZE-1:0]        sum_data_out,
  output logic                             sum_data_out_enable,
  output logic                             sum_ready,
  // Multiplier side
  input  wire logic                        mul_start,
  input  wire logic [`NTM_DATA_SIZE-1:0]   mul_modulo,
  input  wire logic [`NTM_DATA_SIZE-1:0]   mul_a,
  input  wire logic [`NTM_DATA_SIZE-1:0]   mul_b,
  output logic [`NTM_DATA_SIZE-1:0]        mul_data_out,
  output logic                             mul_ready
);

  // Client links
  logic       s_start, s_ready, m_start, m_ready;
  adder_req_t s_req, m_req;
  adder_rsp_t cl_rsp;
  // Arbiter to adder
  logic       a_start, a_ready;
  adder_req_t a_req;
  adder_rsp_t a_rsp;

  ntm_scalar_summation_function i_sum (
    .CLK(CLK), .RST(RST), .START(sum_start), .LENGTH_IN(sum_length),
    .MODULO_IN(sum_modulo), .DATA_IN(sum_data_in), .DATA_IN_ENABLE(sum_data_in_enable),
    .adder_ready(s_ready), .adder_rsp(cl_rsp), .READY(sum_ready),
    .DATA_OUT_ENABLE(sum_data_out_enable), .DATA_OUT(sum_data_out),
    .adder_start(s_start), .adder_req(s_req)
  );

  ntm_scalar_multiplier i_mul (
    .CLK(CLK), .RST(RST), .START(mul_start), .MODULO_IN(mul_modulo),
    .DATA_A_IN(mul_a), .DATA_B_IN(mul_b), .adder_ready(m_ready), .adder_rsp(cl_rsp),
    .READY(mul_ready), .DATA_OUT(mul_data_out), .adder_start(m_start), .adder_req(m_req)
  );

  ntm_adder_arbiter i_arb (
    .CLK(CLK), .RST(RST), .sum_start(s_start), .sum_req(s_req),
    .mul_start(m_start), .mul_req(m_req), .adder_ready(a_ready), .adder_rsp(a_rsp),
    .sum_ready(s_ready), .mul_ready(m_ready), .rsp(cl_rsp),
    .adder_start(a_start), .adder_req(a_req)
  );

  ntm_scalar_adder i_add (
    .CLK(CLK), .RST(RST), .start(a_start), .req(a_req), .ready(a_ready), .rsp(a_rsp)
  );

endmodule

`default_nettype wire

/* tb/ntm_scalar_unit_tb.sv */
// Self-checking testbench for the scalar engine; stops at the first error, moduli are at least 2
`timescale 1ns/1ps
`default_nettype none

`include "ntm_scalar_params.svh"

module ntm_scalar_unit_tb;

  localparam int W            = `NTM_DATA_SIZE;
  localparam int SEED         = 21057;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 20;
  // Test plan sizes
  localparam int N_RAND_SUMS  = 4;
  localparam int MAX_RAND_LEN = 12;
  localparam int MUL_ROUNDS   = 3;
  localparam int N_RAND_MUL   = 4;
  localparam int CONC_ROUNDS  = 2;
  localparam int CONC_LEN     = 6;
  // Lengths 1, 2 and 0 give four inputs
  localparam int SUM_INPUTS   = 4 + N_RAND_SUMS * MAX_RAND_LEN + CONC_ROUNDS * CONC_LEN;
  localparam int PRODUCTS     = MUL_ROUNDS * (5 + N_RAND_MUL) + CONC_ROUNDS;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + 40 * SUM_INPUTS
                                  + 4 * W * 6 * PRODUCTS;

  // Expected partial sum, with the ready it must come with
  typedef struct packed {
    logic [W-1:0] value;
    logic         last;
  } sum_exp_t;

  logic                        CLK;
  logic                        RST;
  logic                        sum_start;
  logic [`NTM_LENGTH_SIZE-1:0] sum_length;
  logic [W-1:0]                sum_modulo;
  logic [W-1:0]                sum_data_in;
  logic                        sum_data_in_enable;
  logic [W-1:0]                sum_data_out;
  logic                        sum_data_out_enable;
  logic                        sum_ready;
  logic                        mul_start;
  logic [W-1:0]                mul_modulo;
  logic [W-1:0]                mul_a;
  logic [W-1:0]                mul_b;
  logic [W-1:0]                mul_data_out;
  logic                        mul_ready;

  sum_exp_t     exp_sum_q[$];
  logic [W-1:0] exp_mul_q[$];
  sum_exp_t     got_sum;
  logic [W-1:0] got_mul;
  int           cycle_count;

  ntm_scalar_unit i_dut (
    .CLK(CLK), .RST(RST),
    .sum_start(sum_start), .sum_length(sum_length), .sum_modulo(sum_modulo),
    .sum_data_in(sum_data_in), .sum_data_in_enable(sum_data_in_enable),
    .sum_data_out(sum_data_out), .sum_data_out_enable(sum_data_out_enable),
    .sum_ready(sum_ready),
    .mul_start(mul_start), .mul_modulo(mul_modulo), .mul_a(mul_a), .mul_b(mul_b),
    .mul_data_out(mul_data_out), .mul_ready(mul_ready)
  );

  // 8 ns period
  always #4 CLK = ~CLK;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [W-1:0] ref_mod_add(input logic [W-1:0] a, input logic [W-1:0] b,
                                               input logic [W-1:0] m);
    logic [31:0] total;
    total = 32'(a) + 32'(b);
    return `NTM_DATA_SIZE'(total % 32'(m));
  endfunction

  // MSB first, doubling then optional add
  function automatic logic [W-1:0] ref_mod_mul(input logic [W-1:0] a, input logic [W-1:0] b,
                                               input logic [W-1:0] m);
    logic [W-1:0] acc;
    acc = '0;
    for (int i = W - 1; i >= 0; i--) begin
      acc = ref_mod_add(acc, acc, m);
      if (b[i]) begin
        acc = ref_mod_add(acc, a, m);
      end
    end
    return acc;
  endfunction

  function automatic logic [W-1:0] random_modulus();
    return `NTM_DATA_SIZE'($urandom_range((1 << W) - 1, 2));
  endfunction

  // Operand already reduced
  function automatic logic [W-1:0] random_below(input logic [W-1:0] m);
    return `NTM_DATA_SIZE'($urandom % 32'(m));
  endfunction

  //////////////////////////////
  // Failure handling
  //////////////////////////////

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR: %s = 0x%h, expected 0x%h", name, actual, expected);
      stop_on_failure();
    end
  endtask

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic wait_sum_out();
    @(negedge CLK);
    while (!sum_data_out_enable) begin
      @(negedge CLK);
    end
  endtask

  task automatic wait_mul_ready();
    @(negedge CLK);
    while (!mul_ready) begin
      @(negedge CLK);
    end
  endtask

  // One input at a time, next one only after the partial sum
  task automatic run_summation(input int len, input logic [W-1:0] m);
    int           count;
    logic [W-1:0] data;
    logic [W-1:0] running;
    count = (len == 0) ? 1 : len;
    running = '0;
    @(posedge CLK);
    sum_start <= 1'b1;
    sum_length <= `NTM_LENGTH_SIZE'(len);
    sum_modulo <= m;
    @(posedge CLK);
    sum_start <= 1'b0;
    for (int i = 0; i < count; i++) begin
      data = random_below(m);
      running = ref_mod_add(running, data, m);
      exp_sum_q.push_back('{value: running, last: (i == count - 1)});
      @(posedge CLK);
      sum_data_in <= data;
      sum_data_in_enable <= 1'b1;
      @(posedge CLK);
      sum_data_in_enable <= 1'b0;
      wait_sum_out();
    end
  endtask

  task automatic run_product(input logic [W-1:0] a, input logic [W-1:0] b,
                             input logic [W-1:0] m);
    exp_mul_q.push_back(ref_mod_mul(a, b, m));
    @(posedge CLK);
    mul_start <= 1'b1;
    mul_a <= a;
    mul_b <= b;
    mul_modulo <= m;
    @(posedge CLK);
    mul_start <= 1'b0;
    wait_mul_ready();
  endtask

  //////////////////////////////
  // Comparison
  //////////////////////////////

  // Outputs settle by the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (sum_data_out_enable) begin
        if (exp_sum_q.size() == 0) begin
          $display("Summation gave a partial sum that no input asked for");
          stop_on_failure();
        end else begin
          got_sum = exp_sum_q.pop_front();
          check_value("sum_data_out", 32'(sum_data_out), 32'(got_sum.value));
          check_value("sum_ready", 32'(sum_ready), 32'(got_sum.last));
        end
      end else if (sum_ready) begin
        $display("Summation raised ready without a partial sum");
        stop_on_failure();
      end
      if (mul_ready) begin
        if (exp_mul_q.size() == 0) begin
          $display("Multiplier raised ready with no product started");
          stop_on_failure();
        end else begin
          got_mul = exp_mul_q.pop_front();
          check_value("mul_data_out", 32'(mul_data_out), 32'(got_mul));
        end
      end
    end
  end

  // Hang guard
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [W-1:0] m;
    logic [W-1:0] x;
    void'($urandom(SEED));
    cycle_count = 0;
    CLK = 1'b0;
    RST = 1'b1;
    sum_start = 1'b0;
    sum_length = '0;
    sum_modulo = '0;
    sum_data_in = '0;
    sum_data_in_enable = 1'b0;
    mul_start = 1'b0;
    mul_modulo = '0;
    mul_a = '0;
    mul_b = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    // Quiet period, any pulse here has no queue entry
    repeat (IDLE_CYCLES) @(posedge CLK);

    // Short lengths, zero runs as one
    run_summation(1, random_modulus());
    run_summation(2, random_modulus());
    run_summation(0, random_modulus());
    for (int r = 0; r < N_RAND_SUMS; r++) begin
      run_summation(int'($urandom_range(MAX_RAND_LEN, 3)), random_modulus());
    end

    // First round uses the largest modulus for the carry path
    for (int r = 0; r < MUL_ROUNDS; r++) begin
      m = (r == 0) ? '1 : random_modulus();
      x = random_below(m);
      run_product('0, x, m);
      run_product(x, '0, m);
      run_product(`NTM_DATA_SIZE'(1), x, m);
      run_product(x, `NTM_DATA_SIZE'(1), m);
      run_product(m - 1'b1, m - 1'b1, m);
      for (int k = 0; k < N_RAND_MUL; k++) begin
        run_product(random_below(m), random_below(m), m);
      end
    end

    // Both clients on the shared adder at once
    for (int r = 0; r < CONC_ROUNDS; r++) begin
      m = random_modulus();
      x = random_below(m);
      fork
        run_summation(CONC_LEN, random_modulus());
        run_product(x, random_below(m), m);
      join
    end

    repeat (4) @(posedge CLK);
    if (exp_sum_q.size() != 0 || exp_mul_q.size() != 0) begin
      $display("Run ended with expected results never produced");
      stop_on_failure();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/ntm_arith_pkg.sv
design/ntm_ctrl_pkg.sv
design/ntm_scalar_adder.sv
design/ntm_adder_arbiter.sv
design/ntm_scalar_summation_function.sv
design/ntm_scalar_multiplier.sv
design/ntm_scalar_unit.sv
tb/ntm_scalar_unit_tb.sv

/* Makefile */
# Verilator build and run of the scalar engine testbench

TOP := ntm_scalar_unit_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG); then echo "No pass result"; exit 1; fi

obj_dir/V$(TOP): filelist.f $(wildcard design/*.sv design/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -j 0 -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
